// ==== src/axil_pkg.sv ====
// AXI4-Lite bus types used on every source and target port of the interconnect
// one request struct toward the subordinate and one response struct back
package axil_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // EXOKAY is never produced here
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // manager to subordinate
    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
        data_t wdata;
        strb_t wstrb;
        logic  wvalid;
        logic  bready;
        addr_t araddr;
        logic  arvalid;
        logic  rready;
    } axil_req_t;

    // subordinate back to manager
    typedef struct packed {
        logic  awready;
        logic  wready;
        resp_e bresp;
        logic  bvalid;
        logic  arready;
        data_t rdata;
        resp_e rresp;
        logic  rvalid;
    } axil_rsp_t;

endpackage

// ==== src/xbar_pkg.sv ====
// internal types of the interconnect for sequencer states, arbiter grant and decode route
package xbar_pkg;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        WRITE,
        WRITE_RESP,
        WRITE_DROP,
        READ,
        WAIT_IDLE
    } xfer_state_e;

    // winning source and direction
    typedef struct packed {
        logic       valid;
        logic       is_read;
        logic [7:0] src;
    } grant_t;

    // target selected by the address decoder
    typedef struct packed {
        logic       hit;
        logic [7:0] tgt;
    } route_t;

endpackage

// ==== src/axil_rr_arbiter.sv ====
// round-robin arbiter over the write and read requests of every source
// request 2s is the write of source s and 2s+1 its read; the grant holds until acknowledge
module axil_rr_arbiter #(
    parameter int S_COUNT = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [2*S_COUNT-1:0] request,
    input  logic                 acknowledge,
    output xbar_pkg::grant_t     grant
);

    localparam int N = 2 * S_COUNT;

    logic [N-1:0]     mask_q;
    logic [N-1:0]     masked;
    xbar_pkg::grant_t pick;
    xbar_pkg::grant_t grant_q;

    always_comb begin
        masked = request & mask_q;
        pick = '0;
        // scan downward so the lowest index wins
        for (int i = N - 1; i >= 0; i--) begin
            if (masked[i] || (masked == '0 && request[i])) begin
                pick.valid = 1'b1;
                pick.is_read = i[0];
                pick.src = 8'(i / 2);
            end
        end
    end

    // live pick until the winner is locked in
    assign grant = grant_q.valid ? grant_q : pick;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= '0;
            mask_q <= '1;
        end else if (grant_q.valid) begin
            if (acknowledge) begin
                grant_q.valid <= 1'b0;
                // only indices above the last winner keep priority
                mask_q <= {N{1'b1}} << (2 * int'(grant_q.src) + int'(grant_q.is_read) + 1);
            end
        end else if (pick.valid) begin
            grant_q <= pick;
        end
    end

endmodule

// ==== src/axil_addr_decode.sv ====
// maps the captured address onto M_COUNT equal, contiguous target windows
// window i starts at BASE_ADDR + i * 2**WIN_BITS
module axil_addr_decode #(
    parameter int              M_COUNT   = 2,
    parameter axil_pkg::addr_t BASE_ADDR = '0,
    parameter int              WIN_BITS  = 12
) (
    input  axil_pkg::addr_t  addr,
    output xbar_pkg::route_t route
);

    // window number of the first target
    localparam axil_pkg::addr_t WIN_BASE = BASE_ADDR >> WIN_BITS;

    axil_pkg::addr_t win;

    assign win = addr >> WIN_BITS;

    always_comb begin
        route = '0;
        // first matching window wins
        for (int i = M_COUNT - 1; i >= 0; i--) begin
            if (win == WIN_BASE + axil_pkg::addr_t'(i)) begin
                route.hit = 1'b1;
                route.tgt = 8'(i);
            end
        end
    end

endmodule

// ==== src/axil_xfer_fsm.sv ====
// transfer sequencer that captures the granted request, forwards it to the decoded target
// and hands the collected response to the response return stage
module axil_xfer_fsm #(
    parameter int S_COUNT = 2,
    parameter int M_COUNT = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  xbar_pkg::grant_t    grant,
    input  xbar_pkg::route_t    route,
    input  axil_pkg::axil_req_t s_req [S_COUNT],
    output logic [S_COUNT-1:0]  s_aw_ready,
    output logic [S_COUNT-1:0]  s_ar_ready,
    output logic [S_COUNT-1:0]  s_w_ready,
    output axil_pkg::axil_req_t m_req [M_COUNT],
    input  axil_pkg::axil_rsp_t m_rsp [M_COUNT],
    output logic                load,
    output logic                load_is_read,
    output axil_pkg::data_t     load_data,
    output axil_pkg::resp_e     load_resp,
    input  logic                done
);

    localparam int SRC_W = (S_COUNT > 1) ? $clog2(S_COUNT) : 1;
    localparam int TGT_W = (M_COUNT > 1) ? $clog2(M_COUNT) : 1;

    xbar_pkg::xfer_state_e state_q;

    logic [SRC_W-1:0]   src;
    logic [TGT_W-1:0]   route_tgt;
    logic [TGT_W-1:0]   tgt_q;
    logic               hit_q;
    axil_pkg::addr_t    addr_q;
    axil_pkg::data_t    data_q;
    axil_pkg::strb_t    strb_q;
    logic [M_COUNT-1:0] aw_valid_q;
    logic [M_COUNT-1:0] w_valid_q;
    logic [M_COUNT-1:0] b_ready_q;
    logic [M_COUNT-1:0] ar_valid_q;
    logic [M_COUNT-1:0] r_ready_q;
    logic [M_COUNT-1:0] m_aw_ready;
    logic [M_COUNT-1:0] m_w_ready;
    logic [M_COUNT-1:0] m_ar_ready;
    logic               s_w_fire;
    logic               m_b_fire;
    logic               m_r_fire;

    assign src = grant.src[SRC_W-1:0];
    assign route_tgt = route.tgt[TGT_W-1:0];

    assign s_w_fire = s_w_ready[src] && s_req[src].wvalid;
    assign m_b_fire = b_ready_q[tgt_q] && m_rsp[tgt_q].bvalid;
    assign m_r_fire = r_ready_q[tgt_q] && m_rsp[tgt_q].rvalid;

    // address and data go to every target and only the selected one sees a valid
    always_comb begin
        for (int m = 0; m < M_COUNT; m++) begin
            m_aw_ready[m] = m_rsp[m].awready;
            m_w_ready[m] = m_rsp[m].wready;
            m_ar_ready[m] = m_rsp[m].arready;
            m_req[m].awaddr = addr_q;
            m_req[m].awvalid = aw_valid_q[m];
            m_req[m].wdata = data_q;
            m_req[m].wstrb = strb_q;
            m_req[m].wvalid = w_valid_q[m];
            m_req[m].bready = b_ready_q[m];
            m_req[m].araddr = addr_q;
            m_req[m].arvalid = ar_valid_q[m];
            m_req[m].rready = r_ready_q[m];
        end
    end

    // response handoff in the cycle of the completing handshake
    always_comb begin
        load = 1'b0;
        load_is_read = grant.is_read;
        load_data = '0;
        load_resp = axil_pkg::OKAY;
        case (state_q)
            xbar_pkg::WRITE_RESP: begin
                load = m_b_fire;
                load_resp = m_rsp[tgt_q].bresp;
            end
            xbar_pkg::WRITE_DROP: begin
                load = s_w_fire;
                load_resp = axil_pkg::DECERR;
            end
            xbar_pkg::READ: begin
                if (hit_q) begin
                    load = m_r_fire;
                    load_data = m_rsp[tgt_q].rdata;
                    load_resp = m_rsp[tgt_q].rresp;
                end else begin
                    // decode miss answers with zero data
                    load = 1'b1;
                    load_resp = axil_pkg::DECERR;
                end
            end
            default: begin
                load = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= xbar_pkg::IDLE;
            s_aw_ready <= '0;
            s_ar_ready <= '0;
            s_w_ready <= '0;
            aw_valid_q <= '0;
            w_valid_q <= '0;
            b_ready_q <= '0;
            ar_valid_q <= '0;
            r_ready_q <= '0;
        end else begin
            s_aw_ready <= '0;
            s_ar_ready <= '0;
            // target valids drop on their own ready in any state
            aw_valid_q <= aw_valid_q & ~m_aw_ready;
            w_valid_q <= w_valid_q & ~m_w_ready;
            ar_valid_q <= ar_valid_q & ~m_ar_ready;
            case (state_q)
                xbar_pkg::IDLE: begin
                    if (grant.valid) begin
                        if (grant.is_read) begin
                            s_ar_ready[src] <= 1'b1;
                        end else begin
                            s_aw_ready[src] <= 1'b1;
                        end
                        state_q <= xbar_pkg::DECODE;
                    end
                end
                xbar_pkg::DECODE: begin
                    if (grant.is_read) begin
                        if (route.hit) begin
                            ar_valid_q[route_tgt] <= 1'b1;
                            r_ready_q[route_tgt] <= 1'b1;
                        end
                        // a miss also passes READ to answer one cycle later
                        state_q <= xbar_pkg::READ;
                    end else begin
                        s_w_ready[src] <= 1'b1;
                        if (route.hit) begin
                            aw_valid_q[route_tgt] <= 1'b1;
                            state_q <= xbar_pkg::WRITE;
                        end else begin
                            state_q <= xbar_pkg::WRITE_DROP;
                        end
                    end
                end
                xbar_pkg::WRITE: begin
                    if (s_w_fire) begin
                        s_w_ready[src] <= 1'b0;
                        w_valid_q[tgt_q] <= 1'b1;
                        b_ready_q[tgt_q] <= 1'b1;
                        state_q <= xbar_pkg::WRITE_RESP;
                    end
                end
                xbar_pkg::WRITE_RESP: begin
                    if (m_b_fire) begin
                        b_ready_q[tgt_q] <= 1'b0;
                        state_q <= xbar_pkg::WAIT_IDLE;
                    end
                end
                xbar_pkg::WRITE_DROP: begin
                    if (s_w_fire) begin
                        s_w_ready[src] <= 1'b0;
                        state_q <= xbar_pkg::WAIT_IDLE;
                    end
                end
                xbar_pkg::READ: begin
                    if (!hit_q) begin
                        state_q <= xbar_pkg::WAIT_IDLE;
                    end else if (m_r_fire) begin
                        r_ready_q[tgt_q] <= 1'b0;
                        state_q <= xbar_pkg::WAIT_IDLE;
                    end
                end
                xbar_pkg::WAIT_IDLE: begin
                    // source has taken the response
                    if (done) begin
                        state_q <= xbar_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= xbar_pkg::IDLE;
                end
            endcase
        end
    end

    // captured address, route and write payload
    always_ff @(posedge clk) begin
        if (state_q == xbar_pkg::IDLE && grant.valid) begin
            addr_q <= grant.is_read ? s_req[src].araddr : s_req[src].awaddr;
        end
        if (state_q == xbar_pkg::DECODE) begin
            hit_q <= route.hit;
            tgt_q <= route_tgt;
        end
        if (state_q == xbar_pkg::WRITE && s_w_fire) begin
            data_q <= s_req[src].wdata;
            strb_q <= s_req[src].wstrb;
        end
    end

endmodule

// ==== src/axil_resp_return.sv ====
// holds the write or read response for the granted source until it is accepted
// the accepting handshake is reported as done to the arbiter and the sequencer
module axil_resp_return #(
    parameter int S_COUNT = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  xbar_pkg::grant_t    grant,
    input  logic                load,
    input  logic                load_is_read,
    input  axil_pkg::data_t     load_data,
    input  axil_pkg::resp_e     load_resp,
    input  axil_pkg::axil_req_t s_req [S_COUNT],
    output logic [S_COUNT-1:0]  b_valid,
    output logic [S_COUNT-1:0]  r_valid,
    output axil_pkg::resp_e     b_resp,
    output axil_pkg::resp_e     r_resp,
    output axil_pkg::data_t     r_data,
    output logic                done
);

    localparam int SRC_W = (S_COUNT > 1) ? $clog2(S_COUNT) : 1;

    logic [SRC_W-1:0]   src;
    logic [S_COUNT-1:0] b_ready;
    logic [S_COUNT-1:0] r_ready;

    always_comb begin
        for (int s = 0; s < S_COUNT; s++) begin
            b_ready[s] = s_req[s].bready;
            r_ready[s] = s_req[s].rready;
        end
    end

    assign src = grant.src[SRC_W-1:0];

    assign done = grant.valid && (grant.is_read ? (r_valid[src] && r_ready[src])
                                                : (b_valid[src] && b_ready[src]));

    always_ff @(posedge clk) begin
        if (rst) begin
            b_valid <= '0;
            r_valid <= '0;
        end else begin
            b_valid <= b_valid & ~b_ready;
            r_valid <= r_valid & ~r_ready;
            if (load) begin
                if (load_is_read) begin
                    r_valid[src] <= 1'b1;
                end else begin
                    b_valid[src] <= 1'b1;
                end
            end
        end
    end

    // response payload shared by all sources
    always_ff @(posedge clk) begin
        if (load) begin
            if (load_is_read) begin
                r_data <= load_data;
                r_resp <= load_resp;
            end else begin
                b_resp <= load_resp;
            end
        end
    end

endmodule

// ==== src/axil_interconnect.sv ====
// AXI4-Lite interconnect, S_COUNT sources to M_COUNT targets, one transaction at a time
// targets occupy equal windows of 2**WIN_BITS bytes starting at BASE_ADDR
module axil_interconnect #(
    parameter int              S_COUNT   = 4,
    parameter int              M_COUNT   = 4,
    parameter axil_pkg::addr_t BASE_ADDR = '0,
    parameter int              WIN_BITS  = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_req_t s_req [S_COUNT],
    output axil_pkg::axil_rsp_t s_rsp [S_COUNT],
    output axil_pkg::axil_req_t m_req [M_COUNT],
    input  axil_pkg::axil_rsp_t m_rsp [M_COUNT]
);

    logic [2*S_COUNT-1:0] request;
    xbar_pkg::grant_t     grant;
    xbar_pkg::route_t     route;
    logic [S_COUNT-1:0]   s_aw_ready;
    logic [S_COUNT-1:0]   s_ar_ready;
    logic [S_COUNT-1:0]   s_w_ready;
    logic [S_COUNT-1:0]   b_valid;
    logic [S_COUNT-1:0]   r_valid;
    logic                 load;
    logic                 load_is_read;
    axil_pkg::data_t      load_data;
    axil_pkg::resp_e      load_resp;
    axil_pkg::resp_e      b_resp;
    axil_pkg::resp_e      r_resp;
    axil_pkg::data_t      r_data;
    logic                 done;

    always_comb begin
        for (int s = 0; s < S_COUNT; s++) begin
            request[2*s] = s_req[s].awvalid;
            request[2*s+1] = s_req[s].arvalid;
            s_rsp[s].awready = s_aw_ready[s];
            s_rsp[s].wready = s_w_ready[s];
            s_rsp[s].bresp = b_resp;
            s_rsp[s].bvalid = b_valid[s];
            s_rsp[s].arready = s_ar_ready[s];
            s_rsp[s].rdata = r_data;
            s_rsp[s].rresp = r_resp;
            s_rsp[s].rvalid = r_valid[s];
        end
    end

    axil_rr_arbiter #(
        .S_COUNT(S_COUNT)
    ) i_arbiter (
        .clk(clk),
        .rst(rst),
        .request(request),
        .acknowledge(done),
        .grant(grant)
    );

    // captured address is driven the same on every target port
    axil_addr_decode #(
        .M_COUNT(M_COUNT),
        .BASE_ADDR(BASE_ADDR),
        .WIN_BITS(WIN_BITS)
    ) i_decode (
        .addr(m_req[0].araddr),
        .route(route)
    );

    axil_xfer_fsm #(
        .S_COUNT(S_COUNT),
        .M_COUNT(M_COUNT)
    ) i_fsm (
        .clk(clk),
        .rst(rst),
        .grant(grant),
        .route(route),
        .s_req(s_req),
        .s_aw_ready(s_aw_ready),
        .s_ar_ready(s_ar_ready),
        .s_w_ready(s_w_ready),
        .m_req(m_req),
        .m_rsp(m_rsp),
        .load(load),
        .load_is_read(load_is_read),
        .load_data(load_data),
        .load_resp(load_resp),
        .done(done)
    );

    axil_resp_return #(
        .S_COUNT(S_COUNT)
    ) i_resp (
        .clk(clk),
        .rst(rst),
        .grant(grant),
        .load(load),
        .load_is_read(load_is_read),
        .load_data(load_data),
        .load_resp(load_resp),
        .s_req(s_req),
        .b_valid(b_valid),
        .r_valid(r_valid),
        .b_resp(b_resp),
        .r_resp(r_resp),
        .r_data(r_data),
        .done(done)
    );

endmodule

// ==== verification/axil_mem_model.sv ====
// behavioural AXI4-Lite memory used as one interconnect target in the testbench
// every handshake and response is answered after a random delay
module axil_mem_model #(
    parameter int ADDR_BITS = 12,
    parameter int SEED      = 32847
) (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_req_t req,
    output axil_pkg::axil_rsp_t rsp
);

    axil_pkg::data_t mem [2**(ADDR_BITS-2)];
    axil_pkg::addr_t aw_addr;
    axil_pkg::addr_t ar_addr;
    axil_pkg::data_t w_data;
    axil_pkg::strb_t w_strb;
    logic            aw_got;
    logic            w_got;
    logic            ar_got;
    int              dly;
    integer          seed = SEED;

    function automatic int next_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            rsp <= '0;
            aw_got <= 1'b0;
            w_got <= 1'b0;
            ar_got <= 1'b0;
            dly <= 0;
        end else begin
            rsp.awready <= 1'b0;
            rsp.wready <= 1'b0;
            rsp.arready <= 1'b0;
            if (req.awvalid && rsp.awready) begin
                aw_got <= 1'b1;
                aw_addr <= req.awaddr;
            end
            if (req.wvalid && rsp.wready) begin
                w_got <= 1'b1;
                w_data <= req.wdata;
                w_strb <= req.wstrb;
            end
            if (req.arvalid && rsp.arready) begin
                ar_got <= 1'b1;
                ar_addr <= req.araddr;
            end
            if (rsp.bvalid && req.bready) begin
                rsp.bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got <= 1'b0;
            end
            if (rsp.rvalid && req.rready) begin
                rsp.rvalid <= 1'b0;
                ar_got <= 1'b0;
            end
            // one action per delay period
            if (dly != 0) begin
                dly <= dly - 1;
            end else if (req.awvalid && !aw_got && !rsp.awready) begin
                rsp.awready <= 1'b1;
                dly <= next_delay();
            end else if (req.wvalid && !w_got && !rsp.wready) begin
                rsp.wready <= 1'b1;
                dly <= next_delay();
            end else if (aw_got && w_got && !rsp.bvalid) begin
                for (int b = 0; b < 4; b++) begin
                    if (w_strb[b]) begin
                        mem[aw_addr[ADDR_BITS-1:2]][8*b +: 8] <= w_data[8*b +: 8];
                    end
                end
                rsp.bresp <= axil_pkg::OKAY;
                rsp.bvalid <= 1'b1;
                dly <= next_delay();
            end else if (req.arvalid && !ar_got && !rsp.arready) begin
                rsp.arready <= 1'b1;
                dly <= next_delay();
            end else if (ar_got && !rsp.rvalid) begin
                rsp.rdata <= mem[ar_addr[ADDR_BITS-1:2]];
                rsp.rresp <= axil_pkg::OKAY;
                rsp.rvalid <= 1'b1;
                dly <= next_delay();
            end
        end
    end

endmodule

// ==== verification/axil_interconnect_assert.sv ====
// concurrent checks on the interconnect ports
// attached to every axil_interconnect instance by the bind at the end of this file
module axil_interconnect_assert #(
    parameter int S_COUNT = 2,
    parameter int M_COUNT = 2
) (
    input logic                clk,
    input logic                rst,
    input axil_pkg::axil_req_t s_req [S_COUNT],
    input axil_pkg::axil_rsp_t s_rsp [S_COUNT],
    input axil_pkg::axil_req_t m_req [M_COUNT]
);

    logic [M_COUNT-1:0] m_addr_valid;
    logic [M_COUNT-1:0] m_any_valid;
    logic [S_COUNT-1:0] s_resp_valid;

    always_comb begin
        for (int m = 0; m < M_COUNT; m++) begin
            m_addr_valid[m] = m_req[m].awvalid | m_req[m].arvalid;
            m_any_valid[m] = m_req[m].awvalid | m_req[m].wvalid | m_req[m].arvalid;
        end
        for (int s = 0; s < S_COUNT; s++) begin
            s_resp_valid[s] = s_rsp[s].bvalid | s_rsp[s].rvalid;
        end
    end

    // one transaction in flight, so one target address at most
    a_one_target: assert property (@(posedge clk) disable iff (rst) $onehot0(m_addr_valid))
        else $error("more than one target address valid at a time");

    a_reset_quiet: assert property (@(posedge clk)
        rst && $past(rst) |-> m_any_valid == '0 && s_resp_valid == '0)
        else $error("valid high while reset is held");

    for (genvar s = 0; s < S_COUNT; s++) begin : g_src
        a_b_hold: assert property (@(posedge clk) disable iff (rst)
            s_rsp[s].bvalid && !s_req[s].bready |=>
                s_rsp[s].bvalid && $stable(s_rsp[s].bresp))
            else $error("source %0d write response changed before bready", s);

        a_r_hold: assert property (@(posedge clk) disable iff (rst)
            s_rsp[s].rvalid && !s_req[s].rready |=>
                s_rsp[s].rvalid && $stable(s_rsp[s].rdata) && $stable(s_rsp[s].rresp))
            else $error("source %0d read response changed before rready", s);
    end

endmodule

bind axil_interconnect axil_interconnect_assert #(
    .S_COUNT(S_COUNT),
    .M_COUNT(M_COUNT)
) i_assert (
    .clk(clk),
    .rst(rst),
    .s_req(s_req),
    .s_rsp(s_rsp),
    .m_req(m_req)
);

// ==== verification/tb_axil_interconnect.sv ====
// testbench for the AXI4-Lite interconnect with two sources and two memory targets
// runs a table of reads and writes, some launched in pairs to exercise arbitration
module tb_axil_interconnect;

    localparam int              S_COUNT     = 2;
    localparam int              M_COUNT     = 2;
    localparam axil_pkg::addr_t BASE_ADDR   = '0;
    localparam int              WIN_BITS    = 12;
    localparam int              DRIVE_DELAY = 10;
    localparam int              NUM_ENTRIES = 22;

    // paired entries start in the same cycle as the entry after them
    typedef struct packed {
        logic [7:0]      src;
        logic            is_read;
        logic            paired;
        logic            slow;
        axil_pkg::addr_t addr;
        axil_pkg::data_t data;
        axil_pkg::strb_t strb;
        axil_pkg::data_t exp_data;
        axil_pkg::resp_e exp_resp;
    } entry_t;

    localparam entry_t TESTS [NUM_ENTRIES] = '{
        '{8'd0, 1'b0, 1'b0, 1'b0, 32'h0000_0010, 32'h1122_3344, 4'hf, 32'h0, axil_pkg::OKAY},
        '{8'd1, 1'b1, 1'b0, 1'b0, 32'h0000_0010, 32'h0, 4'h0, 32'h1122_3344, axil_pkg::OKAY},
        '{8'd1, 1'b0, 1'b0, 1'b0, 32'h0000_1020, 32'hA5A5_5A5A, 4'hf, 32'h0, axil_pkg::OKAY},
        '{8'd0, 1'b1, 1'b0, 1'b0, 32'h0000_1020, 32'h0, 4'h0, 32'hA5A5_5A5A, axil_pkg::OKAY},
        '{8'd0, 1'b0, 1'b0, 1'b0, 32'h0000_1020, 32'h0000_BEEF, 4'h3, 32'h0, axil_pkg::OKAY},
        '{8'd1, 1'b1, 1'b0, 1'b0, 32'h0000_1020, 32'h0, 4'h0, 32'hA5A5_BEEF, axil_pkg::OKAY},
        '{8'd1, 1'b0, 1'b0, 1'b0, 32'h0000_0010, 32'hCC00_0000, 4'h8, 32'h0, axil_pkg::OKAY},
        '{8'd0, 1'b1, 1'b0, 1'b0, 32'h0000_0010, 32'h0, 4'h0, 32'hCC22_3344, axil_pkg::OKAY},
        // outside every window
        '{8'd0, 1'b1, 1'b0, 1'b0, 32'h0000_2000, 32'h0, 4'h0, 32'h0, axil_pkg::DECERR},
        '{8'd1, 1'b0, 1'b0, 1'b0, 32'h8000_0004, 32'hFFFF_FFFF, 4'hf, 32'h0, axil_pkg::DECERR},
        '{8'd1, 1'b1, 1'b0, 1'b0, 32'hFFFF_FFF0, 32'h0, 4'h0, 32'h0, axil_pkg::DECERR},
        // simultaneous writes
        '{8'd0, 1'b0, 1'b1, 1'b0, 32'h0000_0040, 32'h0101_0101, 4'hf, 32'h0, axil_pkg::OKAY},
        '{8'd1, 1'b0, 1'b0, 1'b0, 32'h0000_1040, 32'h0202_0202, 4'hf, 32'h0, axil_pkg::OKAY},
        '{8'd1, 1'b1, 1'b0, 1'b0, 32'h0000_0040, 32'h0, 4'h0, 32'h0101_0101, axil_pkg::OKAY},
        '{8'd0, 1'b1, 1'b0, 1'b0, 32'h0000_1040, 32'h0, 4'h0, 32'h0202_0202, axil_pkg::OKAY},
        '{8'd0, 1'b0, 1'b1, 1'b0, 32'h0000_1044, 32'h0303_0303, 4'hf, 32'h0, axil_pkg::OKAY},
        '{8'd1, 1'b0, 1'b0, 1'b0, 32'h0000_0044, 32'h0404_0404, 4'hf, 32'h0, axil_pkg::OKAY},
        '{8'd0, 1'b1, 1'b0, 1'b0, 32'h0000_0044, 32'h0, 4'h0, 32'h0404_0404, axil_pkg::OKAY},
        '{8'd1, 1'b1, 1'b0, 1'b0, 32'h0000_1044, 32'h0, 4'h0, 32'h0303_0303, axil_pkg::OKAY},
        // read held back by a slow rready while the other source waits
        '{8'd0, 1'b1, 1'b1, 1'b1, 32'h0000_0010, 32'h0, 4'h0, 32'hCC22_3344, axil_pkg::OKAY},
        '{8'd1, 1'b0, 1'b0, 1'b0, 32'h0000_0050, 32'h5555_AAAA, 4'hf, 32'h0, axil_pkg::OKAY},
        '{8'd0, 1'b1, 1'b0, 1'b0, 32'h0000_0050, 32'h0, 4'h0, 32'h5555_AAAA, axil_pkg::OKAY}
    };

    logic                clk = 1'b0;
    logic                rst;
    axil_pkg::axil_req_t s_req [S_COUNT];
    axil_pkg::axil_rsp_t s_rsp [S_COUNT];
    axil_pkg::axil_req_t m_req [M_COUNT];
    axil_pkg::axil_rsp_t m_rsp [M_COUNT];
    integer              seed = 32847;
    logic                miss_watch = 1'b0;
    int                  last_idx = 2 * S_COUNT - 1;
    int                  done_idx [$];

    always #50 clk = ~clk;

    axil_interconnect #(
        .S_COUNT(S_COUNT),
        .M_COUNT(M_COUNT),
        .BASE_ADDR(BASE_ADDR),
        .WIN_BITS(WIN_BITS)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .s_req(s_req),
        .s_rsp(s_rsp),
        .m_req(m_req),
        .m_rsp(m_rsp)
    );

    for (genvar m = 0; m < M_COUNT; m++) begin : g_tgt
        axil_mem_model #(
            .ADDR_BITS(WIN_BITS)
        ) i_mem (
            .clk(clk),
            .rst(rst),
            .req(m_req[m]),
            .rsp(m_rsp[m])
        );
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input axil_pkg::data_t got,
                              input axil_pkg::data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input axil_pkg::resp_e got,
                              input axil_pkg::resp_e exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %b expected %b (%s)", $time, name, got, exp,
                                exp.name()));
        end
    endtask

    task automatic check_quiet();
        for (int s = 0; s < S_COUNT; s++) begin
            if ({s_rsp[s].bvalid, s_rsp[s].rvalid, s_rsp[s].awready, s_rsp[s].arready,
                 s_rsp[s].wready} !== 5'b0) begin
                abort_run($sformatf("source %0d has a valid or ready high after reset", s));
            end
        end
        for (int m = 0; m < M_COUNT; m++) begin
            if ({m_req[m].awvalid, m_req[m].wvalid, m_req[m].arvalid} !== 3'b0) begin
                abort_run($sformatf("target %0d sees a valid after reset", m));
            end
        end
    endtask

    function automatic int ready_delay(input logic slow);
        int r;
        r = $unsigned($random(seed)) % 8;
        if (slow) begin
            return r + 6;
        end
        return r + 1;
    endfunction

    // next request index in rotation after the last winner
    function automatic int rr_winner(input int last, input logic [2*S_COUNT-1:0] req);
        int idx;
        rr_winner = -1;
        for (int k = 2 * S_COUNT; k >= 1; k--) begin
            idx = (last + k) % (2 * S_COUNT);
            if (req[idx]) begin
                rr_winner = idx;
            end
        end
    endfunction

    // one source transaction, started a drive delay after the next rising edge
    task automatic run_entry(input entry_t e, input int hold);
        int    s;
        string tag;
        s = int'(e.src);
        tag = $sformatf("s_rsp[%0d]", s);
        @(posedge clk);
        #DRIVE_DELAY;
        if (e.is_read) begin
            s_req[s].araddr = e.addr;
            s_req[s].arvalid = 1'b1;
            @(posedge clk);
            while (s_rsp[s].arready !== 1'b1) @(posedge clk);
            #DRIVE_DELAY;
            s_req[s].arvalid = 1'b0;
            @(posedge clk);
            while (s_rsp[s].rvalid !== 1'b1) @(posedge clk);
            repeat (hold) begin
                check_data({tag, ".rdata"}, s_rsp[s].rdata, e.exp_data);
                @(posedge clk);
            end
            #DRIVE_DELAY;
            s_req[s].rready = 1'b1;
            @(posedge clk);
            if (s_rsp[s].rvalid !== 1'b1) begin
                abort_run($sformatf("source %0d lost rvalid before accepting it", s));
            end
            check_data({tag, ".rdata"}, s_rsp[s].rdata, e.exp_data);
            check_resp({tag, ".rresp"}, s_rsp[s].rresp, e.exp_resp);
            #DRIVE_DELAY;
            s_req[s].rready = 1'b0;
        end else begin
            s_req[s].awaddr = e.addr;
            s_req[s].awvalid = 1'b1;
            s_req[s].wdata = e.data;
            s_req[s].wstrb = e.strb;
            s_req[s].wvalid = 1'b1;
            @(posedge clk);
            while (s_rsp[s].awready !== 1'b1) @(posedge clk);
            #DRIVE_DELAY;
            s_req[s].awvalid = 1'b0;
            @(posedge clk);
            while (s_rsp[s].wready !== 1'b1) @(posedge clk);
            #DRIVE_DELAY;
            s_req[s].wvalid = 1'b0;
            @(posedge clk);
            while (s_rsp[s].bvalid !== 1'b1) @(posedge clk);
            repeat (hold) begin
                check_resp({tag, ".bresp"}, s_rsp[s].bresp, e.exp_resp);
                @(posedge clk);
            end
            #DRIVE_DELAY;
            s_req[s].bready = 1'b1;
            @(posedge clk);
            if (s_rsp[s].bvalid !== 1'b1) begin
                abort_run($sformatf("source %0d lost bvalid before accepting it", s));
            end
            check_resp({tag, ".bresp"}, s_rsp[s].bresp, e.exp_resp);
            #DRIVE_DELAY;
            s_req[s].bready = 1'b0;
        end
        last_idx = 2 * s + int'(e.is_read);
        done_idx.push_back(last_idx);
    endtask

    // a decode miss must never reach a target
    always @(posedge clk) begin
        for (int m = 0; m < M_COUNT; m++) begin
            if (miss_watch && (m_req[m].awvalid || m_req[m].wvalid || m_req[m].arvalid)) begin
                abort_run($sformatf("target %0d saw a valid during a decode miss", m));
            end
        end
    end

    initial begin
        repeat (10 + 200 * NUM_ENTRIES) @(posedge clk);
        abort_run("watchdog expired before all transactions completed");
    end

    initial begin
        entry_t               e;
        entry_t               f;
        int                   hold_a;
        int                   hold_b;
        int                   base;
        int                   want;
        int                   i;
        logic [2*S_COUNT-1:0] both;
        rst = 1'b1;
        for (int s = 0; s < S_COUNT; s++) begin
            s_req[s] = '0;
        end
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(posedge clk);
        check_quiet();
        i = 0;
        while (i < NUM_ENTRIES) begin
            e = TESTS[i];
            hold_a = ready_delay(e.slow);
            if (e.paired) begin
                f = TESTS[i+1];
                hold_b = ready_delay(f.slow);
                both = '0;
                both[2*int'(e.src) + int'(e.is_read)] = 1'b1;
                both[2*int'(f.src) + int'(f.is_read)] = 1'b1;
                want = rr_winner(last_idx, both);
                base = done_idx.size();
                fork
                    run_entry(e, hold_a);
                    run_entry(f, hold_b);
                join
                if (done_idx[base] != want) begin
                    abort_run($sformatf("ERR %0t grant order got index %0d expected %0d",
                                        $time, done_idx[base], want));
                end
                i += 2;
            end else begin
                miss_watch = (e.exp_resp == axil_pkg::DECERR);
                run_entry(e, hold_a);
                miss_watch = 1'b0;
                i += 1;
            end
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== axil_interconnect.f ====
src/axil_pkg.sv
src/xbar_pkg.sv
src/axil_rr_arbiter.sv
src/axil_addr_decode.sv
src/axil_xfer_fsm.sv
src/axil_resp_return.sv
src/axil_interconnect.sv
verification/axil_mem_model.sv
verification/axil_interconnect_assert.sv
verification/tb_axil_interconnect.sv

// ==== Bender.yml ====
package:
  name: axil_interconnect

sources:
  # design
  - src/axil_pkg.sv
  - src/xbar_pkg.sv
  - src/axil_rr_arbiter.sv
  - src/axil_addr_decode.sv
  - src/axil_xfer_fsm.sv
  - src/axil_resp_return.sv
  - src/axil_interconnect.sv

  # verification
  - target: test
    files:
      - verification/axil_mem_model.sv
      - verification/axil_interconnect_assert.sv
      - verification/tb_axil_interconnect.sv
